//--- filelist.f
+incdir+logic
logic/w5500_pkg.sv
logic/frame_if.sv
logic/init_table.sv
logic/credit_counter.sv
logic/frame_builder.sv
logic/init_sequencer_fsm.sv
logic/w5500_init_top.sv
verif/tb_w5500_init.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the W5500 init testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_w5500_init \
    --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_w5500_init > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0

//--- verif/tb_w5500_init.sv
// Testbench for the W5500 power-up configuration sequencer
// random FIFO credit and SPI busy timing with the frame stream checked against a model

`timescale 1ns/1ps
`default_nettype none

`include "w5500_settings.svh"

module tb_w5500_init;

    localparam int NUM_BYTES    = 51;
    localparam int RESET_CYCLES = 2;
    localparam int QUIET_CYCLES = 50;
    localparam int DEPTH        = `W5500_FIFO_DEPTH;
    localparam int TIMEOUT      = NUM_BYTES * 8 + `W5500_NUM_REGS * 24 + 200;

    typedef enum int {T_RESET, T_STREAM, T_FLOW, T_CMD, T_ORDER, T_DONE, NUM_TESTS} test_t;

    logic        clk       = 1'b0;
    logic        rst       = 1'b1;
    logic        tx_credit = 1'b0;
    logic        busy      = 1'b0;
    logic        tx_valid;
    logic [7:0]  tx_data;
    logic        cmd_start;
    logic [15:0] cmd_bits;
    logic        init_done;

    // reference frames
    logic [7:0]  exp_bytes[$];
    int          frame_of_byte[$];
    int          frame_end[$];
    int          exp_bits[$];

    logic [15:0] lfsr = 16'd24278;
    int          errs [NUM_TESTS] = '{default: 0};
    int          cycle       = 0;
    int          bytes_seen  = 0;
    int          fifo_count  = 0;
    int          credit_wait = 0;
    int          cmd_count   = 0;
    int          busy_falls  = 0;
    int          eng_phase   = 0;
    int          busy_delay  = 0;
    int          busy_len    = 0;
    int          late        = 0;
    int          quiet       = 0;
    logic        done_seen   = 1'b0;
    logic        finished    = 1'b0;

    always #5 clk = ~clk;

    w5500_init_top UUT (
        .clk(clk), .rst(rst), .tx_credit(tx_credit), .busy(busy),
        .tx_valid(tx_valid), .tx_data(tx_data), .cmd_start(cmd_start),
        .cmd_bits(cmd_bits), .init_done(init_done)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic string test_label(input int t);
        case (t)
            T_RESET:  return "reset_values";
            T_STREAM: return "byte_stream";
            T_FLOW:   return "flow_control";
            T_CMD:    return "cmd_frames";
            T_ORDER:  return "busy_order";
            default:  return "done_quiet";
        endcase
    endfunction

    task automatic report_error(input int t, input string what);
        $display("%s: %s", test_label(t), what);
        errs[t] = errs[t] + 1;
    endtask

    task automatic check_value(input int t, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (expected == actual) else begin
            $display("[FAIL] %s: expected %0h, actual %0h", test_label(t), expected, actual);
            errs[t] = errs[t] + 1;
        end
    endtask

    task automatic print_result(input int t);
        if (errs[t] == 0) begin
            $display("%s: pass", test_label(t));
        end else begin
            $display("%s: FAIL with %0d errors", test_label(t), errs[t]);
        end
    endtask

    // header bytes and then data bytes MSB first
    task automatic add_frame(input logic [15:0] addr, input logic [4:0] bsb,
                             input logic [47:0] data, input int nbytes);
        int i;
        for (i = 0; i < nbytes + 3; i++) begin
            frame_of_byte.push_back(frame_end.size());
        end
        exp_bytes.push_back(addr[15:8]);
        exp_bytes.push_back(addr[7:0]);
        exp_bytes.push_back({bsb, 3'b100});
        for (i = nbytes - 1; i >= 0; i--) begin
            exp_bytes.push_back(data[i*8 +: 8]);
        end
        frame_end.push_back(exp_bytes.size());
        exp_bits.push_back((nbytes + 3) * 8);
    endtask

    initial begin
        add_frame(`W5500_ADDR_MR, `W5500_BSB_COMMON, 48'(`W5500_VAL_MR),
                  $bits(`W5500_VAL_MR) / 8);
        add_frame(`W5500_ADDR_IMR, `W5500_BSB_COMMON, 48'(`W5500_VAL_IMR),
                  $bits(`W5500_VAL_IMR) / 8);
        add_frame(`W5500_ADDR_GAR, `W5500_BSB_COMMON, 48'(`W5500_VAL_GAR),
                  $bits(`W5500_VAL_GAR) / 8);
        add_frame(`W5500_ADDR_SUBR, `W5500_BSB_COMMON, 48'(`W5500_VAL_SUBR),
                  $bits(`W5500_VAL_SUBR) / 8);
        add_frame(`W5500_ADDR_SHAR, `W5500_BSB_COMMON, 48'(`W5500_VAL_SHAR),
                  $bits(`W5500_VAL_SHAR) / 8);
        add_frame(`W5500_ADDR_SIPR, `W5500_BSB_COMMON, 48'(`W5500_VAL_SIPR),
                  $bits(`W5500_VAL_SIPR) / 8);
        add_frame(`W5500_ADDR_SIMR, `W5500_BSB_COMMON, 48'(`W5500_VAL_SIMR),
                  $bits(`W5500_VAL_SIMR) / 8);
        add_frame(`W5500_ADDR_SN_MR, `W5500_BSB_SOCKET0, 48'(`W5500_VAL_SN_MR),
                  $bits(`W5500_VAL_SN_MR) / 8);
        add_frame(`W5500_ADDR_SN_PORT, `W5500_BSB_SOCKET0, 48'(`W5500_VAL_SN_PORT),
                  $bits(`W5500_VAL_SN_PORT) / 8);
    end

    //////////////////////////////////////////////////
    // FIFO and SPI engine models and monitors
    //////////////////////////////////////////////////

    // FIFO drains one byte after a random wait and returns its credit
    task automatic return_credit();
        tx_credit = 1'b0;
        if (fifo_count > 0) begin
            if (credit_wait == 0) begin
                tx_credit   = 1'b1;
                fifo_count  = fifo_count - 1;
                credit_wait = draw_bits(3);
            end else begin
                credit_wait = credit_wait - 1;
            end
        end
    endtask

    task automatic watch_command();
        if (cmd_start) begin
            assert (cmd_count < `W5500_NUM_REGS)
                else report_error(T_CMD, "cmd_start pulse after the last frame");
            if (cmd_count < `W5500_NUM_REGS) begin
                check_value(T_CMD, 16'(frame_end[cmd_count]), 16'(bytes_seen));
                check_value(T_CMD, 16'(exp_bits[cmd_count]), cmd_bits);
            end
            assert (!init_done) else report_error(T_DONE, "cmd_start while init_done is high");
            cmd_count = cmd_count + 1;
        end
    endtask

    // a byte on the bus now is taken at the next rising edge
    task automatic accept_byte();
        if (tx_valid) begin
            assert (fifo_count < DEPTH)
                else report_error(T_FLOW, "byte sent with all FIFO slots already in flight");
            fifo_count = fifo_count + 1;
            assert (bytes_seen < exp_bytes.size())
                else report_error(T_STREAM, "byte sent beyond the expected stream");
            if (bytes_seen < exp_bytes.size()) begin
                check_value(T_STREAM, 16'(exp_bytes[bytes_seen]), 16'(tx_data));
                check_value(T_ORDER, 16'(frame_of_byte[bytes_seen]), 16'(busy_falls));
            end
            assert (!init_done) else report_error(T_DONE, "byte sent while init_done is high");
            bytes_seen = bytes_seen + 1;
        end
    endtask

    task automatic run_engine();
        case (eng_phase)
            0: begin
                if (cmd_start) begin
                    busy_delay = draw_bits(2);
                    busy_len   = 1 + draw_bits(4) % 15;
                    eng_phase  = 1;
                end
            end
            1: begin
                if (busy_delay == 0) begin
                    busy      = 1'b1;
                    eng_phase = 2;
                end else begin
                    busy_delay = busy_delay - 1;
                end
            end
            default: begin
                if (busy_len == 1) begin
                    busy       = 1'b0;
                    busy_falls = busy_falls + 1;
                    eng_phase  = 0;
                end else begin
                    busy_len = busy_len - 1;
                end
            end
        endcase
    endtask

    task automatic watch_done();
        if (init_done) begin
            if (!done_seen) begin
                done_seen = 1'b1;
                check_value(T_DONE, 16'(`W5500_NUM_REGS), 16'(busy_falls));
                check_value(T_DONE, 16'(`W5500_NUM_REGS), 16'(cmd_count));
                check_value(T_STREAM, 16'(NUM_BYTES), 16'(bytes_seen));
            end
            quiet = quiet + 1;
            if (quiet == QUIET_CYCLES) begin
                finished = 1'b1;
            end
        end else begin
            assert (!done_seen) else report_error(T_DONE, "init_done dropped without reset");
            if (busy_falls == `W5500_NUM_REGS) begin
                late = late + 1;
                assert (late != 4)
                    else report_error(T_DONE, "init_done missing after last busy fall");
            end
        end
    endtask

    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT) begin
            $display("timeout after %0d cycles with %0d bytes and %0d commands seen",
                     TIMEOUT, bytes_seen, cmd_count);
            $display("tests failed");
            $finish;
        end else if (rst) begin
            if (cycle == RESET_CYCLES) begin
                check_value(T_RESET, 16'd0, 16'(tx_valid));
                check_value(T_RESET, 16'd0, 16'(cmd_start));
                check_value(T_RESET, 16'd0, 16'(init_done));
                check_value(T_RESET, 16'd0, cmd_bits);
                print_result(T_RESET);
                rst = 1'b0;
            end
        end else if (!finished) begin
            return_credit();
            watch_command();
            accept_byte();
            run_engine();
            watch_done();
        end
    end

    initial begin
        int t;
        int total;
        int passed;
        total  = 0;
        passed = 0;
        wait (finished);
        for (t = 1; t < NUM_TESTS; t++) begin
            print_result(t);
        end
        for (t = 0; t < NUM_TESTS; t++) begin
            total = total + errs[t];
            if (errs[t] == 0) begin
                passed = passed + 1;
            end
        end
        $display("summary: %0d of %0d tests ok, %0d errors", passed, NUM_TESTS, total);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/w5500_init_top.sv
// W5500 power-up configuration sequencer, top level
// byte stream to the SPI transmit FIFO with credit flow control,
// command start and bit length to the SPI engine

`timescale 1ns/1ps
`default_nettype none

module w5500_init_top import w5500_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic tx_credit,
    input  wire logic busy,
    output logic      tx_valid,
    output byte_t     tx_data,
    output logic      cmd_start,
    output bit_len_t  cmd_bits,
    output logic      init_done
);

    entry_idx_t idx;
    reg_entry_t tbl_entry;
    logic       has_credit;
    logic       consume;

    frame_if frm ();

    init_table u_table (
        .idx   (idx),
        .entry (tbl_entry)
    );

    credit_counter u_credit (
        .clk           (clk),
        .rst           (rst),
        .credit_return (tx_credit),
        .consume       (consume),
        .has_credit    (has_credit)
    );

    frame_builder u_builder (
        .clk        (clk),
        .rst        (rst),
        .frm        (frm.builder),
        .has_credit (has_credit),
        .consume    (consume),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data)
    );

    init_sequencer_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .frm       (frm.seq),
        .idx       (idx),
        .entry_in  (tbl_entry),
        .busy      (busy),
        .cmd_start (cmd_start),
        .cmd_bits  (cmd_bits),
        .init_done (init_done)
    );

endmodule

`default_nettype wire

//--- logic/init_sequencer_fsm.sv
// Init sequencer FSM
// steps through the register table, hands each entry to the builder,
// starts the SPI command and follows the engine busy handshake

`timescale 1ns/1ps
`default_nettype none

`include "w5500_settings.svh"

module init_sequencer_fsm import w5500_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    frame_if.seq            frm,
    output entry_idx_t      idx,
    input  wire reg_entry_t entry_in,
    input  wire logic       busy,
    output logic            cmd_start,
    output bit_len_t        cmd_bits,
    output logic            init_done
);

    localparam entry_idx_t LAST_IDX = entry_idx_t'(`W5500_NUM_REGS - 1);

    seq_state_t state;

    // table read is combinational, entry matches idx in the same cycle
    assign frm.entry = entry_in;
    assign frm.load  = (state == ST_LOAD);
    assign cmd_start = (state == ST_START);
    assign init_done = (state == ST_DONE);

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            idx      <= '0;
            cmd_bits <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    state <= ST_LOAD;
                end
                ST_LOAD: begin
                    state <= ST_SEND;
                end
                // wait for the builder to push the whole frame
                ST_SEND: begin
                    if (frm.sent) begin
                        cmd_bits <= bit_len_t'(frm.byte_count) << 3;
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    state <= ST_WAIT_BUSY;
                end
                // engine picks the command up
                ST_WAIT_BUSY: begin
                    if (busy) begin
                        state <= ST_WAIT_IDLE;
                    end
                end
                // frame shifted out, next entry or finish
                ST_WAIT_IDLE: begin
                    if (!busy) begin
                        if (idx == LAST_IDX) begin
                            state <= ST_DONE;
                        end else begin
                            idx   <= idx + entry_idx_t'(1);
                            state <= ST_LOAD;
                        end
                    end
                end
                ST_DONE: begin
                    state <= ST_DONE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_builder.sv
// SPI write frame builder
// address high, address low, control byte, then data MSB first,
// one byte per credited cycle

`timescale 1ns/1ps
`default_nettype none

module frame_builder import w5500_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    frame_if.builder  frm,
    input  wire logic has_credit,
    output logic      consume,
    output logic      tx_valid,
    output byte_t     tx_data
);

    reg_entry_t ent;
    logic [3:0] pos;
    logic       active;

    reg_entry_t cur_entry;
    logic [3:0] cur_pos;
    logic [3:0] cur_total;
    logic       more;
    logic       launch;

    // control byte: block select, write bit, variable length mode
    function automatic byte_t frame_byte(input reg_entry_t e, input logic [3:0] p);
        logic [3:0] k;
        k = {1'b0, e.nbytes} + 4'd2 - p;
        case (p)
            4'd0:    frame_byte = e.addr[15:8];
            4'd1:    frame_byte = e.addr[7:0];
            4'd2:    frame_byte = {e.bsb, 1'b1, 2'b00};
            default: frame_byte = e.data[{k[2:0], 3'b000} +: 8];
        endcase
    endfunction

    //////////////////////////////////////////////////
    // next byte selection
    //////////////////////////////////////////////////

    // on load the first byte comes straight from the new entry
    always_comb begin
        cur_entry = frm.load ? frm.entry : ent;
        cur_pos   = frm.load ? 4'd0 : pos;
        cur_total = 4'd3 + {1'b0, cur_entry.nbytes};
        more      = frm.load || active;
        launch    = more && has_credit;
    end

    assign consume        = tx_valid;
    assign frm.byte_count = 4'd3 + {1'b0, ent.nbytes};

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            active   <= 1'b0;
            pos      <= '0;
            frm.sent <= 1'b0;
        end else begin
            tx_valid <= launch;
            if (launch) begin
                pos    <= cur_pos + 4'd1;
                active <= (cur_pos + 4'd1 != cur_total);
            end else if (frm.load) begin
                pos    <= '0;
                active <= 1'b1;
            end
            // last byte is on the bus once nothing is left pending
            if (frm.load) begin
                frm.sent <= 1'b0;
            end else if (tx_valid && !active) begin
                frm.sent <= 1'b1;
            end
        end
    end

    // payload, tx_data holds while stalled
    always_ff @(posedge clk) begin
        if (frm.load) begin
            ent <= frm.entry;
        end
        if (launch) begin
            tx_data <= frame_byte(cur_entry, cur_pos);
        end
    end

endmodule

`default_nettype wire

//--- logic/credit_counter.sv
// Transmit FIFO credit counter
// free slot count, up on returned credit, down on each sent byte

`timescale 1ns/1ps
`default_nettype none

`include "w5500_settings.svh"

module credit_counter (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic credit_return,
    input  wire logic consume,
    output logic      has_credit
);

    localparam int DEPTH = `W5500_FIFO_DEPTH;
    localparam int CW    = $clog2(DEPTH + 1);

    logic [CW-1:0] count;
    logic [CW-1:0] count_next;

    // simultaneous return and consume cancel out
    always_comb begin
        count_next = count;
        if (credit_return && !consume && count != CW'(DEPTH)) begin
            count_next = count + CW'(1);
        end else if (consume && !credit_return && count != '0) begin
            count_next = count - CW'(1);
        end
    end

    // looks one cycle ahead so a registered byte never lands on zero credit
    assign has_credit = (count_next != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= CW'(DEPTH);
        end else begin
            count <= count_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/init_table.sv
// Power-up register table
// nine W5500 write entries, combinational read by entry number

`timescale 1ns/1ps
`default_nettype none

`include "w5500_settings.svh"

module init_table import w5500_pkg::*; (
    input  wire entry_idx_t idx,
    output reg_entry_t      entry
);

    function automatic reg_entry_t mk_entry(
        input logic [15:0] addr,
        input logic [4:0]  bsb,
        input logic [47:0] data,
        input logic [2:0]  nbytes
    );
        reg_entry_t e;
        e.addr   = addr;
        e.bsb    = bsb;
        e.data   = data;
        e.nbytes = nbytes;
        return e;
    endfunction

    //////////////////////////////////////////////////
    // write order: common block first, socket 0 last
    //////////////////////////////////////////////////

    always_comb begin
        case (idx)
            4'd0: entry = mk_entry(`W5500_ADDR_MR, `W5500_BSB_COMMON,
                                   48'(`W5500_VAL_MR), 3'd1);
            4'd1: entry = mk_entry(`W5500_ADDR_IMR, `W5500_BSB_COMMON,
                                   48'(`W5500_VAL_IMR), 3'd1);
            // gateway
            4'd2: entry = mk_entry(`W5500_ADDR_GAR, `W5500_BSB_COMMON,
                                   48'(`W5500_VAL_GAR), 3'd4);
            // subnet mask
            4'd3: entry = mk_entry(`W5500_ADDR_SUBR, `W5500_BSB_COMMON,
                                   48'(`W5500_VAL_SUBR), 3'd4);
            // MAC address, the only 6 byte write
            4'd4: entry = mk_entry(`W5500_ADDR_SHAR, `W5500_BSB_COMMON,
                                   `W5500_VAL_SHAR, 3'd6);
            // source IP
            4'd5: entry = mk_entry(`W5500_ADDR_SIPR, `W5500_BSB_COMMON,
                                   48'(`W5500_VAL_SIPR), 3'd4);
            4'd6: entry = mk_entry(`W5500_ADDR_SIMR, `W5500_BSB_COMMON,
                                   48'(`W5500_VAL_SIMR), 3'd1);
            // socket 0 register block from here on
            4'd7: entry = mk_entry(`W5500_ADDR_SN_MR, `W5500_BSB_SOCKET0,
                                   48'(`W5500_VAL_SN_MR), 3'd1);
            4'd8: entry = mk_entry(`W5500_ADDR_SN_PORT, `W5500_BSB_SOCKET0,
                                   48'(`W5500_VAL_SN_PORT), 3'd2);
            default: entry = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/frame_if.sv
// Frame handoff between sequencer and frame builder
// one table entry in, sent level and frame length back

`timescale 1ns/1ps
`default_nettype none

interface frame_if import w5500_pkg::*; ();

    // one-cycle pulse, entry is sampled with it
    logic       load;
    reg_entry_t entry;

    // high from last byte transferred until next load
    logic       sent;
    // header bytes plus data bytes
    logic [3:0] byte_count;

    modport seq (
        output load, entry,
        input  sent, byte_count
    );

    modport builder (
        input  load, entry,
        output sent, byte_count
    );

endinterface

`default_nettype wire

//--- logic/w5500_pkg.sv
// W5500 init types
// byte, index and length types, table entry layout and sequencer states

`default_nettype none

package w5500_pkg;

    // one byte on the SPI stream
    typedef logic [7:0] byte_t;

    // position in the configuration table
    typedef logic [3:0] entry_idx_t;

    // SPI command length in bits
    typedef logic [15:0] bit_len_t;

    //////////////////////////////////////////////////
    // table entry
    //////////////////////////////////////////////////

    // data is right-aligned, nbytes runs 1..6
    typedef struct packed {
        logic [15:0] addr;
        logic [4:0]  bsb;
        logic [47:0] data;
        logic [2:0]  nbytes;
    } reg_entry_t;

    //////////////////////////////////////////////////
    // sequencer states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SEND,
        ST_START,
        ST_WAIT_BUSY,
        ST_WAIT_IDLE,
        ST_DONE
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/w5500_settings.svh
// W5500 power-up configuration constants
// FIFO depth, table length, block selects, register addresses and values
`ifndef W5500_SETTINGS_SVH
`define W5500_SETTINGS_SVH

`define W5500_FIFO_DEPTH    4
`define W5500_NUM_REGS      9

// block select field of the control byte
`define W5500_BSB_COMMON    5'b00000
`define W5500_BSB_SOCKET0   5'b00001

// register offsets
`define W5500_ADDR_MR       16'h0000
`define W5500_ADDR_IMR      16'h0016
`define W5500_ADDR_GAR      16'h0001
`define W5500_ADDR_SUBR     16'h0005
`define W5500_ADDR_SHAR     16'h0009
`define W5500_ADDR_SIPR     16'h000F
`define W5500_ADDR_SIMR     16'h0018
`define W5500_ADDR_SN_MR    16'h0000
`define W5500_ADDR_SN_PORT  16'h0004

// values written at power-up, width gives the data byte count
`define W5500_VAL_MR        8'h00
`define W5500_VAL_IMR       8'h00
`define W5500_VAL_GAR       32'hC0A80101
`define W5500_VAL_SUBR      32'hFFFFFF00
`define W5500_VAL_SHAR      48'h05689C010503
`define W5500_VAL_SIPR      32'hC0A80102
`define W5500_VAL_SIMR      8'h01
`define W5500_VAL_SN_MR     8'h01
`define W5500_VAL_SN_PORT   16'h1388

`endif
